//--- icache.f
rtl/icache_addr_pkg.sv
rtl/icache_line_pkg.sv
rtl/icache_way_array.sv
rtl/icache_ctrl.sv
rtl/icache_hit_select.sv
rtl/icache_top.sv
bench/icache_asserts.sv
bench/icache_checker.sv
bench/icache_tb.sv

//--- Makefile
# Verilator build and run of the icache testbench
TOP := icache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f icache.f -Mdir obj_dir

# a simulator abort leaves the fail message in the log as well
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Test failures found (simulator error exit)" >> sim.log
	cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "RESULT: FAIL"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  localparam int mix_cycles = 2000;
  localparam int done_test  = 7;
  // reset, tests 1 to 6, wind down, margin
  localparam int max_cycles = 5 + 21 + 11 + 8 + 11 + 7 + (mix_cycles + 3) + 4 + 50;

  logic                     clk, rst_n, re, we, hit, fill;
  icache_addr_pkg::addr_t   addr, wr_addr;
  icache_line_pkg::line_t   wr_data;
  icache_line_pkg::instr_t  instr;
  icache_addr_pkg::tag_t    set_tags [4][4];  // read candidates per mix set
  icache_addr_pkg::tag_t    next_tag;         // fresh tags only, so no duplicates
  int                       test_num, errors, cycle_cnt, rs, fs, ft;

  icache_top dut0 (
    .clk(clk), .rst_n(rst_n), .i_re(re), .i_addr(addr), .i_we(we),
    .i_wr_addr(wr_addr), .i_wr_data(wr_data), .o_hit(hit), .o_instr(instr)
  );

  icache_checker chk0 (
    .clk(clk), .rst_n(rst_n), .i_re(re), .i_addr(addr), .i_we(we), .i_wr_addr(wr_addr),
    .i_wr_data(wr_data), .i_hit(hit), .i_instr(instr), .i_test_num(test_num),
    .o_errors(errors)
  );

  bind icache_ctrl icache_asserts asserts0 (
    .clk(clk), .rst_n(rst_n), .i_we(i_we), .i_way_we(o_way_we), .i_state(state_q),
    .i_way_hit(i_way_hit)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles)
    begin
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic icache_addr_pkg::addr_t make_addr(input icache_addr_pkg::tag_t t,
      input icache_addr_pkg::index_t s, input icache_addr_pkg::word_sel_t w);
    return {t, s, w, 2'b00};  // tag, set, word, byte
  endfunction

  function automatic icache_line_pkg::line_t rand_line();
    icache_line_pkg::line_t l;
    for (int i = 0; i < 8; i++)
      l[i*32 +: 32] = $urandom;
    return l;
  endfunction

  function automatic icache_addr_pkg::index_t mix_set(input int n);
    return icache_addr_pkg::index_t'(9 + 37 * n);  // sets 9, 46, 83, 120
  endfunction

  // one cycle of inputs, sampled at the following edge
  task automatic drive(input logic r, input icache_addr_pkg::addr_t a, input logic w,
      input icache_addr_pkg::addr_t wa, input icache_line_pkg::line_t d);
    @(posedge clk);
    re <= r;
    addr <= a;
    we <= w;
    wr_addr <= wa;
    wr_data <= d;
  endtask

  task automatic read_at(input icache_addr_pkg::tag_t t, input icache_addr_pkg::index_t s,
      input icache_addr_pkg::word_sel_t w);
    drive(1'b1, make_addr(t, s, w), 1'b0, '0, '0);
  endtask

  // strobe, then stay quiet while the line is written
  task automatic refill_at(input icache_addr_pkg::tag_t t, input icache_addr_pkg::index_t s);
    drive(1'b0, '0, 1'b1, make_addr(t, s, 3'd0), rand_line());
    drive(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic begin_test(input int n);
    drive(1'b0, '0, 1'b0, '0, '0);
    test_num <= n;
  endtask

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b1;  // reset is high
    re = 1'b0;
    we = 1'b0;
    addr = '0;
    wr_addr = '0;
    wr_data = '0;
    test_num = 0;
    cycle_cnt = 0;
    fill = 1'b0;
    ft = 0;
    void'($urandom(32'h423f));
    next_tag = 20'h12340;
    foreach (set_tags[i, j])
      set_tags[i][j] = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;

    begin_test(1);  // cold cache
    repeat (20) drive(1'b1, $urandom, 1'b0, '0, '0);

    begin_test(2);  // every word of one line
    refill_at(20'h0abcd, 7'd5);
    for (int w = 0; w < 8; w++)
      read_at(20'h0abcd, 7'd5, icache_addr_pkg::word_sel_t'(w));

    begin_test(3);  // two tags in one set, all-ones tag usable
    refill_at(20'hfffff, 7'd9);
    refill_at(20'h00001, 7'd9);
    read_at(20'hfffff, 7'd9, 3'd0);
    read_at(20'h00001, 7'd9, 3'd7);
    read_at(20'hfffff, 7'd9, 3'd7);

    begin_test(4);  // hit on a leaves b as victim
    refill_at(20'h00a0a, 7'd20);
    refill_at(20'h00b0b, 7'd20);
    read_at(20'h00a0a, 7'd20, 3'd1);
    refill_at(20'h00c0c, 7'd20);
    read_at(20'h00b0b, 7'd20, 3'd2);  // evicted
    read_at(20'h00a0a, 7'd20, 3'd3);
    read_at(20'h00c0c, 7'd20, 3'd4);

    begin_test(5);
    refill_at(20'h00d0d, 7'd30);
    drive(1'b0, '0, 1'b1, make_addr(20'h00e0e, 7'd30, 3'd0), rand_line());
    read_at(20'h00d0d, 7'd30, 3'd5);  // lands on the write edge, dropped
    drive(1'b0, '0, 1'b0, '0, '0);
    read_at(20'h00d0d, 7'd30, 3'd5);

    begin_test(6);  // random reads and refills over four sets
    repeat (mix_cycles)
    begin
      rs = $urandom % 4;
      fs = $urandom % 4;
      fill = ($urandom % 6) == 0;
      if (fill)
      begin
        ft = $urandom % 4;
        set_tags[fs][ft] = next_tag;
        next_tag = next_tag + 1'b1;
      end
      drive(($urandom % 4) != 0,
            make_addr(set_tags[rs][$urandom % 4], mix_set(rs),
                      icache_addr_pkg::word_sel_t'($urandom)),
            fill, make_addr(set_tags[fs][ft], mix_set(fs), 3'd0), rand_line());
    end
    drive(1'b0, '0, 1'b0, '0, '0);
    drive(1'b0, '0, 1'b0, '0, '0);

    begin_test(done_test);
    repeat (2) @(posedge clk);  // checker prints its closing line
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- bench/icache_checker.sv
`timescale 1ns/1ps

// reference cache model, compared with the dut outputs every cycle
module icache_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_re,
  input  icache_addr_pkg::addr_t   i_addr,
  input  logic                     i_we,
  input  icache_addr_pkg::addr_t   i_wr_addr,
  input  icache_line_pkg::line_t   i_wr_data,
  input  logic                     i_hit,
  input  icache_line_pkg::instr_t  i_instr,
  input  int                       i_test_num,
  output int                       o_errors
);

  localparam int num_tests = 6;  // higher test numbers mean the run is over

  icache_addr_pkg::tag_t    m_tag   [2][icache_addr_pkg::num_sets];
  logic                     m_valid [2][icache_addr_pkg::num_sets];
  icache_line_pkg::line_t   m_line  [2][icache_addr_pkg::num_sets];
  logic                     m_lru   [icache_addr_pkg::num_sets];  // victim way per set
  logic                     pend;       // refill captured, lands next edge
  icache_addr_pkg::addr_t   pend_addr;
  icache_line_pkg::line_t   pend_line;
  logic                     exp_hit;
  icache_line_pkg::instr_t  exp_instr;
  int                       cur_test, test_checks, test_hits, test_errs, total_checks, errs;

  assign o_errors = errs;

  initial
  begin
    pend = 1'b0;
    exp_hit = 1'b0;
    exp_instr = '0;
    cur_test = 0;
    test_checks = 0;
    test_hits = 0;
    test_errs = 0;
    total_checks = 0;
    errs = 0;
  end

  // ----------------------------------------
  // model, one step per clock edge
  // ----------------------------------------
  always @(posedge clk)
  begin
    logic                     read_ok;
    icache_addr_pkg::index_t  s;
    logic                     way;
    read_ok = i_re && !i_we && !pend;  // refill wins, no reads while a line lands
    exp_hit = 1'b0;
    exp_instr = '0;
    if (rst_n)
    begin
      for (int i = 0; i < icache_addr_pkg::num_sets; i++)
      begin
        m_valid[0][i] = 1'b0;
        m_valid[1][i] = 1'b0;
        m_lru[i] = 1'b0;  // way 0 first victim
      end
      pend = 1'b0;
    end
    else
    begin
      s = i_addr[11:5];
      for (int w = 0; w < 2; w++)
      begin
        if (read_ok && m_valid[w][s] && (m_tag[w][s] == i_addr[31:12]))
        begin
          exp_hit = 1'b1;
          exp_instr = m_line[w][s][int'(i_addr[4:2]) * 32 +: 32];
          m_lru[s] = (w == 0);  // other way becomes victim
        end
      end
      if (pend)
      begin
        s = pend_addr[11:5];
        way = m_lru[s];
        m_tag[way][s] = pend_addr[31:12];
        m_line[way][s] = pend_line;
        m_valid[way][s] = 1'b1;
        m_lru[s] = !way;  // filled way most recent
        pend = 1'b0;
      end
      else if (i_we)
      begin
        pend = 1'b1;
        pend_addr = i_wr_addr;
        pend_line = i_wr_data;
      end
    end
  end

  // ----------------------------------------
  // compare mid cycle, report per test
  // ----------------------------------------
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      test_checks++;
      total_checks++;
      if (exp_hit)
        test_hits++;
      if ((i_hit !== exp_hit) || (i_instr !== exp_instr))
      begin
        errs++;
        test_errs++;
        $display("CHECK FAILED t=%0t: test %0d got hit %b instr %h, expected hit %b instr %h",
                 $time, cur_test, i_hit, i_instr, exp_hit, exp_instr);
      end
    end
    if (i_test_num != cur_test)
    begin
      if (cur_test != 0)
        $display("test %0d done: %0d checks, %0d hits, %0d errors",
                 cur_test, test_checks, test_hits, test_errs);
      if (i_test_num > num_tests)
        $display("closing: %0d checks, %0d errors", total_checks, errs);
      cur_test = i_test_num;
      test_checks = 0;
      test_hits = 0;
      test_errs = 0;
    end
  end

endmodule

//--- bench/icache_asserts.sv
`timescale 1ns/1ps

// fill write enables and lookup hits, bound into icache_ctrl
module icache_asserts (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  i_we,
  input  logic [icache_line_pkg::num_ways-1:0]  i_way_we,
  input  icache_line_pkg::fill_state_e          i_state,
  input  logic [icache_line_pkg::num_ways-1:0]  i_way_hit
);

  // an accepted strobe lands in exactly one way on the next edge
  way_we_onehot: assert property (@(posedge clk) disable iff (rst_n)
    (i_we && (i_state == icache_line_pkg::fill_idle)) |=> $onehot(i_way_we))
    else $error("refill strobe did not raise exactly one way write enable");

  // write cycle only right after an accepted strobe, one cycle long
  way_we_in_fill: assert property (@(posedge clk) disable iff (rst_n)
    (|i_way_we) |-> ((i_state == icache_line_pkg::fill_write) &&
                     $past(i_we && (i_state == icache_line_pkg::fill_idle))))
    else $error("way write enable raised without an accepted refill strobe");

  // a tag is never resident twice in a set
  hit_not_both: assert property (@(posedge clk) disable iff (rst_n) !(&i_way_hit))
    else $error("lookup hit in both ways at once");

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps

// two-way instruction cache, 128 sets of 256-bit lines
module icache_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_re,
  input  icache_addr_pkg::addr_t   i_addr,
  input  logic                     i_we,
  input  icache_addr_pkg::addr_t   i_wr_addr,
  input  icache_line_pkg::line_t   i_wr_data,
  output logic                     o_hit,
  output icache_line_pkg::instr_t  o_instr
);

  // ctrl to ways
  icache_addr_pkg::index_t                 rd_index;
  logic [icache_line_pkg::num_ways-1:0]    way_we;
  icache_addr_pkg::index_t                 wr_index;
  icache_addr_pkg::tag_t                   wr_tag;
  icache_line_pkg::line_t                  wr_line;

  // request fields, one cycle behind i_re
  logic                                    req_valid;
  icache_addr_pkg::tag_t                   req_tag;
  icache_addr_pkg::word_sel_t              req_word;

  // way read data
  icache_addr_pkg::tag_t                   tag0, tag1;
  logic                                    valid0, valid1;
  icache_line_pkg::line_t                  line0, line1;
  logic [icache_line_pkg::num_ways-1:0]    way_hit;  // back to ctrl for lru

  icache_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_re        (i_re),
    .i_addr      (i_addr),
    .i_we        (i_we),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_way_hit   (way_hit),
    .o_rd_index  (rd_index),
    .o_way_we    (way_we),
    .o_wr_index  (wr_index),
    .o_wr_tag    (wr_tag),
    .o_wr_line   (wr_line),
    .o_req_valid (req_valid),
    .o_req_tag   (req_tag),
    .o_req_word  (req_word)
  );

  // ----------------------------------------
  // ways share everything but the write enable
  // ----------------------------------------
  icache_way_array way0_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rd_index (rd_index),
    .i_we       (way_we[0]),
    .i_wr_index (wr_index),
    .i_wr_tag   (wr_tag),
    .i_wr_line  (wr_line),
    .o_tag      (tag0),
    .o_valid    (valid0),
    .o_line     (line0)
  );

  icache_way_array way1_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rd_index (rd_index),
    .i_we       (way_we[1]),
    .i_wr_index (wr_index),
    .i_wr_tag   (wr_tag),
    .i_wr_line  (wr_line),
    .o_tag      (tag1),
    .o_valid    (valid1),
    .o_line     (line1)
  );

  icache_hit_select u_hit_select (
    .i_req_valid (req_valid),
    .i_req_tag   (req_tag),
    .i_req_word  (req_word),
    .i_tag0      (tag0),
    .i_tag1      (tag1),
    .i_valid0    (valid0),
    .i_valid1    (valid1),
    .i_line0     (line0),
    .i_line1     (line1),
    .o_way_hit   (way_hit),
    .o_hit       (o_hit),
    .o_instr     (o_instr)
  );

endmodule

//--- rtl/icache_hit_select.sv
`timescale 1ns/1ps

// tag compare of both ways and instruction pick
module icache_hit_select (
  input  logic                                  i_req_valid,
  input  icache_addr_pkg::tag_t                 i_req_tag,
  input  icache_addr_pkg::word_sel_t            i_req_word,
  input  icache_addr_pkg::tag_t                 i_tag0,
  input  icache_addr_pkg::tag_t                 i_tag1,
  input  logic                                  i_valid0,
  input  logic                                  i_valid1,
  input  icache_line_pkg::line_t                i_line0,
  input  icache_line_pkg::line_t                i_line1,
  output logic [icache_line_pkg::num_ways-1:0]  o_way_hit,
  output logic                                  o_hit,
  output icache_line_pkg::instr_t               o_instr
);

  icache_line_pkg::line_t  hit_line;

  // a stale or empty entry never matches
  assign o_way_hit[0] = i_req_valid && i_valid0 && (i_tag0 == i_req_tag);
  assign o_way_hit[1] = i_req_valid && i_valid1 && (i_tag1 == i_req_tag);
  assign o_hit        = |o_way_hit;

  assign hit_line = o_way_hit[1] ? i_line1 : i_line0;

  // word mux, zero on a miss
  always_comb
  begin
    o_instr = '0;
    for (int w = 0; w < icache_line_pkg::words_per_line; w++)
    begin
      if (o_hit && (i_req_word == w))
        o_instr = hit_line[w*icache_line_pkg::instr_w +: icache_line_pkg::instr_w];
    end
  end

endmodule

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps

// refill fsm, request pipeline register and lru bits
module icache_ctrl (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    i_re,
  input  icache_addr_pkg::addr_t                  i_addr,
  input  logic                                    i_we,
  input  icache_addr_pkg::addr_t                  i_wr_addr,
  input  icache_line_pkg::line_t                  i_wr_data,
  input  logic [icache_line_pkg::num_ways-1:0]    i_way_hit,
  output icache_addr_pkg::index_t                 o_rd_index,
  output logic [icache_line_pkg::num_ways-1:0]    o_way_we,
  output icache_addr_pkg::index_t                 o_wr_index,
  output icache_addr_pkg::tag_t                   o_wr_tag,
  output icache_line_pkg::line_t                  o_wr_line,
  output logic                                    o_req_valid,
  output icache_addr_pkg::tag_t                   o_req_tag,
  output icache_addr_pkg::word_sel_t              o_req_word
);

  icache_line_pkg::fill_state_e          state_q;
  logic [icache_addr_pkg::num_sets-1:0]  lru_q;        // names the victim way per set
  icache_addr_pkg::index_t               req_index_q;  // set of the read in flight
  icache_line_pkg::way_t                 victim;
  logic                                  filling;
  logic                                  read_ok;

  // ----------------------------------------
  // lookup side
  // ----------------------------------------
  // ways sample the index on the same edge as the request regs
  assign o_rd_index = i_addr[icache_addr_pkg::index_lsb +: icache_addr_pkg::index_w];

  // refill strobe wins, reads are ignored while the line lands
  assign read_ok = i_re && !i_we && (state_q == icache_line_pkg::fill_idle);

  always_ff @(posedge clk)
  begin
    if (rst_n)
      o_req_valid <= 1'b0;
    else
      o_req_valid <= read_ok;
  end

  always_ff @(posedge clk)
  begin
    if (read_ok)
    begin
      req_index_q <= o_rd_index;
      o_req_tag   <= i_addr[icache_addr_pkg::tag_lsb +: icache_addr_pkg::tag_w];
      o_req_word  <= i_addr[icache_addr_pkg::word_lsb +: icache_addr_pkg::word_w];
    end
  end

  // ----------------------------------------
  // refill side
  // ----------------------------------------
  assign filling = (state_q == icache_line_pkg::fill_write);
  assign victim  = lru_q[o_wr_index];

  // one-hot write enable into the lru victim
  assign o_way_we[0] = filling && (victim == icache_line_pkg::way_t'(0));
  assign o_way_we[1] = filling && (victim == icache_line_pkg::way_t'(1));

  always_ff @(posedge clk)
  begin
    if (rst_n)
      state_q <= icache_line_pkg::fill_idle;
    else
    begin
      case (state_q)
        icache_line_pkg::fill_idle:
          if (i_we)
            state_q <= icache_line_pkg::fill_write;
        icache_line_pkg::fill_write:
          state_q <= icache_line_pkg::fill_idle;  // single write cycle
        default:
          state_q <= icache_line_pkg::fill_idle;
      endcase
    end
  end

  // capture address and line with the strobe
  always_ff @(posedge clk)
  begin
    if (i_we && !filling)
    begin
      o_wr_index <= i_wr_addr[icache_addr_pkg::index_lsb +: icache_addr_pkg::index_w];
      o_wr_tag   <= i_wr_addr[icache_addr_pkg::tag_lsb +: icache_addr_pkg::tag_w];
      o_wr_line  <= i_wr_data;
    end
  end

  // lru points at the way not used last
  // fill and hit update never meet on one edge, fill listed first anyway
  always_ff @(posedge clk)
  begin
    if (rst_n)
      lru_q <= '0;  // way 0 is first victim
    else if (filling)
      lru_q[o_wr_index] <= ~victim;  // filled way becomes most recent
    else if (i_way_hit[0])
      lru_q[req_index_q] <= 1'b1;
    else if (i_way_hit[1])
      lru_q[req_index_q] <= 1'b0;
  end

endmodule

//--- rtl/icache_way_array.sv
`timescale 1ns/1ps

// one way of the cache
// data, tag and valid bit per set, read port registered
module icache_way_array (
  input  logic                     clk,
  input  logic                     rst_n,
  input  icache_addr_pkg::index_t  i_rd_index,
  input  logic                     i_we,
  input  icache_addr_pkg::index_t  i_wr_index,
  input  icache_addr_pkg::tag_t    i_wr_tag,
  input  icache_line_pkg::line_t   i_wr_line,
  output icache_addr_pkg::tag_t    o_tag,
  output logic                     o_valid,
  output icache_line_pkg::line_t   o_line
);

  icache_line_pkg::line_t                line_mem [icache_addr_pkg::num_sets];
  icache_addr_pkg::tag_t                 tag_mem  [icache_addr_pkg::num_sets];
  logic [icache_addr_pkg::num_sets-1:0]  valid_q;  // one bit per set

  // storage, write port and registered read
  always_ff @(posedge clk)
  begin
    if (i_we)
    begin
      line_mem[i_wr_index] <= i_wr_line;
      tag_mem[i_wr_index]  <= i_wr_tag;
    end
    o_line <= line_mem[i_rd_index];  // old data on a same-set write
    o_tag  <= tag_mem[i_rd_index];
  end

  // valid bits, cleared at reset so any tag value is usable
  always_ff @(posedge clk)
  begin
    if (rst_n)
    begin
      valid_q <= '0;
      o_valid <= 1'b0;
    end
    else
    begin
      if (i_we)
        valid_q[i_wr_index] <= 1'b1;  // set on every fill
      o_valid <= valid_q[i_rd_index];
    end
  end

endmodule

//--- rtl/icache_line_pkg.sv
// ----------------------------------------
// cache line, way and refill fsm types
// ----------------------------------------
package icache_line_pkg;

  localparam int instr_w        = 32;
  localparam int words_per_line = 8;
  localparam int line_w         = instr_w * words_per_line;  // 256 bit line
  localparam int num_ways       = 2;

  typedef logic [instr_w-1:0]           instr_t;
  typedef logic [line_w-1:0]            line_t;  // word 0 in the low bits
  typedef logic [$clog2(num_ways)-1:0]  way_t;

  // refill sequencing
  // fill_idle takes reads and refill strobes
  // fill_write writes the captured line into the lru victim
  typedef enum logic [0:0] {
    fill_idle,
    fill_write
  } fill_state_e;

endpackage

//--- rtl/icache_addr_pkg.sv
// ----------------------------------------
// fetch address geometry
// ----------------------------------------
package icache_addr_pkg;

  localparam int addr_w    = 32;  // byte address of a fetch

  // field positions inside the address
  localparam int word_lsb  = 2;   // word slot inside the line
  localparam int word_w    = 3;
  localparam int index_lsb = 5;   // set select
  localparam int index_w   = 7;
  localparam int tag_lsb   = 12;  // physical tag, no translation
  localparam int tag_w     = 20;

  localparam int num_sets  = 1 << index_w;  // 128 sets

  // bits 1..0 are the byte offset in the word, never looked at

  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [tag_w-1:0]   tag_t;      // addr[31:12]
  typedef logic [index_w-1:0] index_t;    // addr[11:5]
  typedef logic [word_w-1:0]  word_sel_t; // addr[4:2]

endpackage
